// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= rv32_frontend_tb
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Checks failed" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/rv32_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_decode (
    input  wire logic  clk,
    input  wire logic  reset_,
    input  wire logic  flush,
    rv32_fetch_if.sink in,
    output logic       decoded_valid,
    output rv32_frontend_pkg::decoded_t decoded
);
    import rv32_isa_pkg::*;
    import rv32_frontend_pkg::*;

    logic [31:0] instr;
    op_class_t   op_class;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] imm;

    assign instr = in.pkt.instr;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'd0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (instr[6:0])
            opcode_lui:    op_class = class_lui;
            opcode_auipc:  op_class = class_auipc;
            opcode_jal:    op_class = class_jal;
            opcode_jalr:   op_class = class_jalr;
            opcode_branch: op_class = class_branch;
            opcode_load:   op_class = class_load;
            opcode_store:  op_class = class_store;
            opcode_op_imm: op_class = class_op_imm;
            opcode_op:     op_class = class_op;
            opcode_system: op_class = class_system;
            default:       op_class = class_illegal;
        endcase
    end

    // immediate format follows the class; r-type has none.
    always_comb begin
        case (op_class)
            class_lui, class_auipc: imm = imm_u;
            class_jal:              imm = imm_j;
            class_branch:           imm = imm_b;
            class_store:            imm = imm_s;
            class_jalr, class_load, class_op_imm, class_system: imm = imm_i;
            default:                imm = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_ || flush) begin
            decoded_valid <= 1'b0;
        end else if (!in.stall) begin
            decoded_valid <= in.valid;
        end
    end

    // payload holds while stalled.
    always_ff @(posedge clk) begin
        if (!in.stall && in.valid) begin
            decoded <= '{
                pc:              in.pkt.pc,
                op_class:        op_class,
                rd:              instr[11:7],
                rs1:             instr[19:15],
                rs2:             instr[24:20],
                imm:             imm,
                predicted_taken: in.pkt.predicted_taken
            };
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv32_fetch.sv ====
`timescale 1ns/10ps
`include "rv32_frontend_cfg.svh"
`default_nettype none

module rv32_fetch (
    input  wire logic        clk,
    input  wire logic        reset_,
    input  wire logic        redirect,
    input  wire logic [31:0] redirect_pc,
    input  wire logic        flush,
    input  wire logic [31:0] instr_read_value,
    output logic             instr_read,
    output logic [31:0]      instr_address,
    rv32_fetch_if.source     out
);
    import rv32_isa_pkg::*;
    import rv32_frontend_pkg::*;

    localparam fetch_pkt_t nop_pkt = '{
        pc:              32'd0,
        instr:           instr_nop,
        predicted_taken: 1'b0
    };

    logic [31:0] pc;
    logic [6:0]  opcode;
    logic        sign;
    logic [31:0] imm_j;
    logic [31:0] imm_b;
    logic        predict_taken;
    logic [31:0] pc_offset;

    // the memory answers in the same cycle.
    assign instr_read = 1'b1;
    assign instr_address = pc;

    assign opcode = instr_read_value[6:0];
    assign sign = instr_read_value[31];

    assign imm_j = {{12{sign}}, instr_read_value[19:12], instr_read_value[20],
                    instr_read_value[30:21], 1'b0};
    assign imm_b = {{20{sign}}, instr_read_value[7], instr_read_value[30:25],
                    instr_read_value[11:8], 1'b0};

    // static prediction: jal always, backward branches taken.
    always_comb begin
        predict_taken = 1'b0;
        pc_offset = 32'd4;
        if (opcode == opcode_jal) begin
            predict_taken = 1'b1;
            pc_offset = imm_j;
        end else if (opcode == opcode_branch && sign) begin
            predict_taken = 1'b1;
            pc_offset = imm_b;
        end
    end

    // redirect wins over the stall hold.
    always_ff @(posedge clk) begin
        if (!reset_) begin
            pc <= `RV32_RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!out.stall) begin
            pc <= pc + pc_offset;
        end
    end

    // output register, one cycle behind the address.
    always_ff @(posedge clk) begin
        if (!reset_) begin
            out.valid <= 1'b0;
            out.pkt <= nop_pkt;
        end else if (flush) begin
            // a held item is killed too, so nothing stale enters the queue.
            out.valid <= 1'b0;
            out.pkt <= nop_pkt;
        end else if (!out.stall) begin
            out.valid <= 1'b1;
            out.pkt <= '{
                pc:              pc,
                instr:           instr_read_value,
                predicted_taken: predict_taken
            };
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv32_fetch_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface rv32_fetch_if;
    import rv32_frontend_pkg::*;

    logic       valid;
    fetch_pkt_t pkt;
    logic       stall;

    // the source holds valid and pkt while stall is high.
    modport source (
        output valid,
        output pkt,
        input  stall
    );

    modport sink (
        input  valid,
        input  pkt,
        output stall
    );

endinterface

`default_nettype wire

// ==== hw/rv32_fetch_queue.sv ====
`timescale 1ns/10ps
`include "rv32_frontend_cfg.svh"
`default_nettype none

module rv32_fetch_queue (
    input  wire logic  clk,
    input  wire logic  reset_,
    input  wire logic  flush,
    rv32_fetch_if.sink   in,
    rv32_fetch_if.source out
);
    import rv32_frontend_pkg::*;

    localparam int depth = `RV32_FETCH_QUEUE_DEPTH;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);
    localparam logic [cnt_w-1:0] full_count = cnt_w'(depth);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);

    fetch_pkt_t entries [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == last_ptr) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push = in.valid && !in.stall;
    assign pop = out.valid && !out.stall;

    // stall comes from the registered count only.
    assign in.stall = (count == full_count);

    // oldest entry is always at the read pointer.
    assign out.valid = (count != '0);
    assign out.pkt = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (!reset_ || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in.pkt;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv32_frontend.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_frontend (
    input  wire logic        clk,
    input  wire logic        reset_,
    input  wire logic        redirect,
    input  wire logic [31:0] redirect_pc,
    input  wire logic        flush,
    input  wire logic        decode_stall,
    input  wire logic [31:0] instr_read_value,
    output logic             instr_read,
    output logic [31:0]      instr_address,
    output logic             decoded_valid,
    output logic [31:0]      decoded_pc,
    output rv32_isa_pkg::op_class_t decoded_op_class,
    output logic [4:0]       decoded_rd,
    output logic [4:0]       decoded_rs1,
    output logic [4:0]       decoded_rs2,
    output logic [31:0]      decoded_imm,
    output logic             decoded_predicted_taken
);
    import rv32_frontend_pkg::*;

    decoded_t decoded;

    rv32_fetch_if fq_if ();
    rv32_fetch_if qd_if ();

    // later stages hold decode through the queue link.
    assign qd_if.stall = decode_stall;

    rv32_fetch i_rv32_fetch (
        .clk              (clk),
        .reset_           (reset_),
        .redirect         (redirect),
        .redirect_pc      (redirect_pc),
        .flush            (flush),
        .instr_read_value (instr_read_value),
        .instr_read       (instr_read),
        .instr_address    (instr_address),
        .out              (fq_if.source)
    );

    rv32_fetch_queue i_rv32_fetch_queue (
        .clk    (clk),
        .reset_ (reset_),
        .flush  (flush),
        .in     (fq_if.sink),
        .out    (qd_if.source)
    );

    rv32_decode i_rv32_decode (
        .clk           (clk),
        .reset_        (reset_),
        .flush         (flush),
        .in            (qd_if.sink),
        .decoded_valid (decoded_valid),
        .decoded       (decoded)
    );

    assign decoded_pc = decoded.pc;
    assign decoded_op_class = decoded.op_class;
    assign decoded_rd = decoded.rd;
    assign decoded_rs1 = decoded.rs1;
    assign decoded_rs2 = decoded.rs2;
    assign decoded_imm = decoded.imm;
    assign decoded_predicted_taken = decoded.predicted_taken;

endmodule

`default_nettype wire

// ==== hw/rv32_frontend_cfg.svh ====
`ifndef RV32_FRONTEND_CFG_SVH
`define RV32_FRONTEND_CFG_SVH

// first PC fetched after reset.
`define RV32_RESET_PC 32'h0000_0000

// entries between fetch and decode; 4 also works.
`define RV32_FETCH_QUEUE_DEPTH 2

`endif

// ==== hw/rv32_frontend_pkg.sv ====
`default_nettype none

package rv32_frontend_pkg;

    // one fetched instruction with the PC it came from.
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic        predicted_taken;
    } fetch_pkt_t;

    typedef struct packed {
        logic [31:0]             pc;
        rv32_isa_pkg::op_class_t op_class;
        logic [4:0]              rd;
        logic [4:0]              rs1;
        logic [4:0]              rs2;
        logic [31:0]             imm;
        logic                    predicted_taken;
    } decoded_t;

endpackage

`default_nettype wire

// ==== hw/rv32_isa_pkg.sv ====
`default_nettype none

package rv32_isa_pkg;

    // major opcodes, bits [6:0] of the instruction word.
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_auipc  = 7'b0010111;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_system = 7'b1110011;

    // addi x0, x0, 0.
    localparam logic [31:0] instr_nop = 32'h0000_0013;

    typedef enum logic [3:0] {
        class_lui,
        class_auipc,
        class_jal,
        class_jalr,
        class_branch,
        class_load,
        class_store,
        class_op_imm,
        class_op,
        class_system,
        class_illegal
    } op_class_t;

endpackage

`default_nettype wire

// ==== list.f ====
+incdir+hw
hw/rv32_isa_pkg.sv
hw/rv32_frontend_pkg.sv
hw/rv32_fetch_if.sv
hw/rv32_fetch.sv
hw/rv32_fetch_queue.sv
hw/rv32_decode.sv
hw/rv32_frontend.sv
testbench/rv32_frontend_assert.sv
testbench/rv32_frontend_tb.sv

// ==== testbench/frontend_input.txt ====
// words 0-63: instruction memory, 8 words per line starting at address 0.
// then the event count, then one pair per cycle: flags (bit0 stall, bit1 flush, bit2 redirect), target.
00500093 FFF08113 002081B3 12345237 00322423 FFC22283 00208463 00001317
FE031CE3 00000013 00000013 00000013 00000013 00000013 00000013 00000013
0062E3B3 00008067 010000EF 00000073 00000073 00000073 00140413 FEDFF06F
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000013 00000013 00000013 00000013 00000013 00000013 00000013 00000013
00000028
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
1 0 1 0 1 0 1 0
1 0 1 0 1 0 1 0
6 40 0 0 0 0 0 0
0 0 0 0 0 0 0 0
1 0 1 0 1 0 1 0
1 0 1 0 0 0 0 0
7 C 0 0 0 0 0 0

// ==== testbench/rv32_frontend_assert.sv ====
`timescale 1ns/10ps
`include "rv32_frontend_cfg.svh"
`default_nettype none

module rv32_frontend_assert (
    input wire logic clk,
    input wire logic reset_,
    input wire logic flush,
    input wire logic [$clog2(`RV32_FETCH_QUEUE_DEPTH + 1)-1:0] count,
    input wire logic in_valid,
    input wire logic in_stall,
    input wire logic out_valid,
    input wire logic out_stall,
    input wire rv32_frontend_pkg::fetch_pkt_t out_pkt
);

    localparam int occ_w = $clog2(`RV32_FETCH_QUEUE_DEPTH + 1);

    logic [occ_w-1:0] occupancy;
    logic             in_xfer;
    logic             out_xfer;

    assign in_xfer = in_valid && !in_stall;
    assign out_xfer = out_valid && !out_stall;

    // entries held, counted from the transfers seen on both links.
    always_ff @(posedge clk) begin
        if (!reset_ || flush) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + occ_w'(in_xfer) - occ_w'(out_xfer);
        end
    end

    count_in_range: assert property (@(posedge clk) disable iff (!reset_)
        count <= `RV32_FETCH_QUEUE_DEPTH)
        else $error("queue count above depth");

    stall_when_full: assert property (@(posedge clk) disable iff (!reset_)
        in_stall == (occupancy == `RV32_FETCH_QUEUE_DEPTH))
        else $error("queue stall does not match the number of held entries");

    // a held head entry must not change under back-pressure.
    head_stable: assert property (@(posedge clk) disable iff (!reset_ || flush)
        (out_valid && out_stall) |=> $stable(out_pkt))
        else $error("queue head changed while stalled");

endmodule

bind rv32_fetch_queue rv32_frontend_assert i_rv32_frontend_assert (
    .clk       (clk),
    .reset_    (reset_),
    .flush     (flush),
    .count     (count),
    .in_valid  (in.valid),
    .in_stall  (in.stall),
    .out_valid (out.valid),
    .out_stall (out.stall),
    .out_pkt   (out.pkt)
);

`default_nettype wire

// ==== testbench/rv32_frontend_tb.sv ====
`timescale 1ns/10ps
`include "rv32_frontend_cfg.svh"
`default_nettype none

module rv32_frontend_tb;
    import rv32_isa_pkg::*;

    localparam int mem_words = 64;
    localparam int max_events = 40;
    localparam int drain_cycles = 10 * (`RV32_FETCH_QUEUE_DEPTH + 3);

    logic        clk;
    logic        reset_;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        flush;
    logic        decode_stall;
    logic [31:0] instr_read_value;
    logic        instr_read;
    logic [31:0] instr_address;
    logic        decoded_valid;
    logic [31:0] decoded_pc;
    op_class_t   decoded_op_class;
    logic [4:0]  decoded_rd;
    logic [4:0]  decoded_rs1;
    logic [4:0]  decoded_rs2;
    logic [31:0] decoded_imm;
    logic        decoded_predicted_taken;

    // memory image, then the event count, then flag and target pairs.
    logic [31:0] data [0:mem_words + 2 * max_events];

    int          errors;
    int          items;
    int          cycles;
    int          limit;
    int          num_events;
    logic [31:0] lcg_state;
    logic [31:0] exp_pc;
    logic [31:0] last_pc;
    logic        seen_reset;
    logic        seen_stall;
    logic        seen_flush;
    logic        seen_redirect;
    logic [31:0] seen_redirect_pc;

    rv32_frontend i_rv32_frontend (
        .clk                     (clk),
        .reset_                  (reset_),
        .redirect                (redirect),
        .redirect_pc             (redirect_pc),
        .flush                   (flush),
        .decode_stall            (decode_stall),
        .instr_read_value        (instr_read_value),
        .instr_read              (instr_read),
        .instr_address           (instr_address),
        .decoded_valid           (decoded_valid),
        .decoded_pc              (decoded_pc),
        .decoded_op_class        (decoded_op_class),
        .decoded_rd              (decoded_rd),
        .decoded_rs1             (decoded_rs1),
        .decoded_rs2             (decoded_rs2),
        .decoded_imm             (decoded_imm),
        .decoded_predicted_taken (decoded_predicted_taken)
    );

    // same-cycle instruction memory.
    assign instr_read_value = data[instr_address[7:2]];

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] imm_of(input logic [31:0] w);
        logic [31:0] sh11;
        logic [31:0] sh19;
        logic [31:0] sh20;
        // the word shifted right with its sign bit copied in.
        sh11 = $signed(w) >>> 11;
        sh19 = $signed(w) >>> 19;
        sh20 = $signed(w) >>> 20;
        case (w[6:0])
            opcode_lui, opcode_auipc: return w & 32'hffff_f000;
            opcode_jal: return (sh11 & 32'hfff0_0000) | (32'(w[19:12]) << 12)
                               | (32'(w[20]) << 11) | (32'(w[30:21]) << 1);
            opcode_branch: return (sh19 & 32'hffff_f000) | (32'(w[7]) << 11)
                                  | (32'(w[30:25]) << 5) | (32'(w[11:8]) << 1);
            opcode_store: return (sh20 & ~32'h1f) | 32'(w[11:7]);
            opcode_jalr, opcode_load, opcode_op_imm, opcode_system:
                return sh20;
            default: return 32'd0;
        endcase
    endfunction

    function automatic op_class_t class_of(input logic [31:0] w);
        case (w[6:0])
            opcode_lui:    return class_lui;
            opcode_auipc:  return class_auipc;
            opcode_jal:    return class_jal;
            opcode_jalr:   return class_jalr;
            opcode_branch: return class_branch;
            opcode_load:   return class_load;
            opcode_store:  return class_store;
            opcode_op_imm: return class_op_imm;
            opcode_op:     return class_op;
            opcode_system: return class_system;
            default:       return class_illegal;
        endcase
    endfunction

    // jal is always taken, and a branch only with a negative offset.
    function automatic logic predicted(input logic [31:0] w);
        return (w[6:0] == opcode_jal) || (w[6:0] == opcode_branch && w[31]);
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic compare_decoded(input logic [31:0] pc);
        logic [31:0] w;
        w = data[pc[7:2]];
        check_value(decoded_pc, pc, "decoded_pc");
        check_value(32'(decoded_op_class), 32'(class_of(w)), "decoded_op_class");
        check_value(32'(decoded_rd), 32'(w[11:7]), "decoded_rd");
        check_value(32'(decoded_rs1), 32'(w[19:15]), "decoded_rs1");
        check_value(32'(decoded_rs2), 32'(w[24:20]), "decoded_rs2");
        check_value(decoded_imm, imm_of(w), "decoded_imm");
        check_value(32'(decoded_predicted_taken), 32'(predicted(w)), "predicted_taken");
    endtask

    task automatic accept_item();
        logic [31:0] w;
        w = data[exp_pc[7:2]];
        compare_decoded(exp_pc);
        last_pc = exp_pc;
        items++;
        if (predicted(w)) begin
            exp_pc = exp_pc + imm_of(w);
        end else begin
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    // what the DUT saw on the last rising edge.
    always @(posedge clk) begin
        seen_reset <= reset_;
        seen_stall <= decode_stall;
        seen_flush <= flush;
        seen_redirect <= redirect;
        seen_redirect_pc <= redirect_pc;
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (cycles >= 1) begin
            check_value(32'(instr_read), 32'd1, "instr_read");
            if (!seen_reset) begin
                check_value(32'(decoded_valid), 32'd0, "decoded_valid in reset");
            end else if (seen_flush) begin
                check_value(32'(decoded_valid), 32'd0, "decoded_valid after flush");
                if (seen_redirect) begin
                    exp_pc = seen_redirect_pc;
                end
            end else if (decoded_valid && !seen_stall) begin
                accept_item();
            end else if (decoded_valid) begin
                compare_decoded(last_pc);
            end
        end
    end

    initial begin
        logic [31:0] flags;
        clk = 1'b0;
        reset_ = 1'b0;
        redirect = 1'b0;
        redirect_pc = 32'd0;
        flush = 1'b0;
        decode_stall = 1'b0;
        errors = 0;
        items = 0;
        cycles = 0;
        limit = 0;
        lcg_state = 32'heb49_6af9;
        exp_pc = `RV32_RESET_PC;
        last_pc = 32'd0;
        seen_reset = 1'b0;
        seen_stall = 1'b0;
        seen_flush = 1'b0;
        seen_redirect = 1'b0;
        seen_redirect_pc = 32'd0;
        $readmemh("testbench/frontend_input.txt", data);
        num_events = int'(data[mem_words]);
        limit = 20 * num_events;

        repeat (3) @(posedge clk);
        reset_ <= 1'b1;
        for (int i = 0; i < num_events; i++) begin
            @(posedge clk);
            flags = data[mem_words + 1 + 2 * i];
            lcg_state = lcg_next(lcg_state);
            decode_stall <= flags[0] || (lcg_state[31:29] == 3'd0);
            flush <= flags[1];
            redirect <= flags[2];
            redirect_pc <= data[mem_words + 2 + 2 * i];
        end
        @(posedge clk);
        decode_stall <= 1'b0;
        flush <= 1'b0;
        redirect <= 1'b0;
        repeat (drain_cycles) @(posedge clk);

        if (items < 20) begin
            errors++;
            $display("too few decoded items: only %0d were seen", items);
        end
        $display("errors: %0d, decoded items checked: %0d", errors, items);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
